//--- Makefile
# Verilator build and run of the egress subsystem testbench

VERILATOR ?= verilator
TOP       ?= egr_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SRCS    := $(filter %.sv %.v,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Status comes from the search for the pass message
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- egr_pkg.sv
/*
  Egress package
  Packet tag, egress port word and read generator state types
*/
`default_nettype none

package egr_pkg;

  // ====================
  // Widths
  // ====================

  // Port index, same as the memory sideband port
  localparam int egr_port_w = smm_pkg::smm_sb_port_w;

  // Word count field, coded as count minus one
  localparam int egr_cnt_w = $clog2(smm_pkg::smm_seg_words);

  // Segment pointer, upper part of a word address
  localparam int egr_seg_ptr_w = smm_pkg::smm_addr_w - egr_cnt_w;

  // ====================
  // Records
  // ====================

  // One packet tag
  typedef struct packed {
    logic [egr_seg_ptr_w-1:0] seg_ptr;
    // 0 means one word, 3 means four
    logic [egr_cnt_w-1:0]     word_cnt;
    logic [egr_port_w-1:0]    port;
  } egr_tag_t;

  // One word on an egress port
  typedef struct packed {
    logic                            valid;
    logic                            sop;
    logic                            eop;
    logic [smm_pkg::smm_word_w-1:0]  data;
  } egr_port_word_t;

  // ====================
  // States
  // ====================

  // Read request generator
  typedef enum logic [1:0] {
    IDLE,
    POP,
    WAIT_PORT,
    READ
  } egr_rd_state_e;

endpackage

`default_nettype wire

//--- egr_port_tx.sv
/*
  Egress port transmit stage
  Steers each read response onto the output register of its port,
  with start and end of packet marks
*/
`default_nettype none
`timescale 1ns/100ps

module egr_port_tx #(
  parameter int NUM_PORTS = 4
) (
  input  logic                   egress_clock,
  input  logic                   rst,
  input  logic                   rsp_valid,
  input  smm_pkg::smm_rd_rsp_t   rd_rsp,
  output egr_pkg::egr_port_word_t port_out [NUM_PORTS]
);

  localparam int PORT_W = egr_pkg::egr_port_w;

  // Per port registers
  logic [NUM_PORTS-1:0]           valid_q;
  logic [NUM_PORTS-1:0]           sop_q;
  logic [NUM_PORTS-1:0]           eop_q;
  logic [smm_pkg::smm_word_w-1:0] data_q [NUM_PORTS];

  // One hot port select
  logic [NUM_PORTS-1:0] port_hit;

  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      port_hit[p] = rsp_valid && (rd_rsp.port == PORT_W'(p));
    end
  end

  // ====================
  // Valid bits
  // ====================
  // Cleared each cycle, set only on the hit port
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= port_hit;
    end
  end

  // ====================
  // Payload
  // ====================
  always_ff @(posedge egress_clock) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (port_hit[p]) begin
        data_q[p] <= rd_rsp.data;
        sop_q[p]  <= rd_rsp.sop;
        eop_q[p]  <= rd_rsp.eop;
      end
    end
  end

  // Pack into port words
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      port_out[p].valid = valid_q[p];
      port_out[p].sop   = sop_q[p];
      port_out[p].eop   = eop_q[p];
      port_out[p].data  = data_q[p];
    end
  end

endmodule

`default_nettype wire

//--- egr_rd_req_gen.sv
/*
  Egress read request generator
  Pops one tag at a time, waits for its port to be enabled and
  issues one segment memory read per word with start and end marks
*/
`default_nettype none
`timescale 1ns/100ps

module egr_rd_req_gen #(
  parameter int NUM_PORTS = 4,
  parameter int MEM_SEGS  = 64
) (
  input  logic                 egress_clock,
  input  logic                 rst,
  input  egr_pkg::egr_tag_t    head_tag,
  input  logic                 not_empty,
  input  logic [NUM_PORTS-1:0] port_enable,
  output logic                 pop,
  output logic                 rd_valid,
  output smm_pkg::smm_rd_req_t rd_req
);

  localparam int SEG_PTR_W = $clog2(MEM_SEGS);
  localparam int ADDR_W    = smm_pkg::smm_addr_w;
  localparam int CNT_W     = egr_pkg::egr_cnt_w;

  egr_pkg::egr_rd_state_e state_q;
  egr_pkg::egr_rd_state_e state_d;

  // Tag being served
  egr_pkg::egr_tag_t tag_q;
  logic [CNT_W-1:0]  word_idx_q;

  logic head_port_en;
  logic tag_port_en;
  logic last_word;

  // Enable of the head tag's port while popping
  assign head_port_en = port_enable[head_tag.port];
  // Enable of the latched tag's port while waiting
  assign tag_port_en  = port_enable[tag_q.port];
  assign last_word    = (word_idx_q == tag_q.word_cnt);

  // ====================
  // Next state
  // ====================
  always_comb begin
    state_d = state_q;
    case (state_q)
      egr_pkg::IDLE: begin
        if (not_empty) begin
          state_d = egr_pkg::POP;
        end
      end
      // Port already on, so the first read follows directly
      egr_pkg::POP: begin
        state_d = head_port_en ? egr_pkg::READ : egr_pkg::WAIT_PORT;
      end
      // Head tag blocks everything behind it
      egr_pkg::WAIT_PORT: begin
        if (tag_port_en) begin
          state_d = egr_pkg::READ;
        end
      end
      // Runs to completion once started
      egr_pkg::READ: begin
        if (last_word) begin
          state_d = egr_pkg::IDLE;
        end
      end
      default: state_d = egr_pkg::IDLE;
    endcase
  end

  always_ff @(posedge egress_clock) begin
    if (rst) begin
      state_q <= egr_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ====================
  // Tag and word index
  // ====================
  always_ff @(posedge egress_clock) begin
    if (state_q == egr_pkg::POP) begin
      tag_q <= head_tag;
    end
  end

  always_ff @(posedge egress_clock) begin
    if (rst) begin
      word_idx_q <= '0;
    end else if (state_q == egr_pkg::POP) begin
      word_idx_q <= '0;
    end else if (state_q == egr_pkg::READ) begin
      word_idx_q <= word_idx_q + 1'b1;
    end
  end

  // ====================
  // Outputs
  // ====================
  assign pop      = (state_q == egr_pkg::POP);
  assign rd_valid = (state_q == egr_pkg::READ);

  // Word address is pointer times 4 plus index
  assign rd_req.addr = ADDR_W'({tag_q.seg_ptr[SEG_PTR_W-1:0], word_idx_q});
  assign rd_req.port = tag_q.port;
  assign rd_req.sop  = (word_idx_q == '0);
  assign rd_req.eop  = last_word;

endmodule

`default_nettype wire

//--- egr_seg_mem.sv
/*
  Egress segment memory
  Word array written by a plain strobe, read with one cycle of latency;
  request sideband travels with the read data
*/
`default_nettype none
`timescale 1ns/100ps

module egr_seg_mem #(
  parameter int MEM_SEGS = 64
) (
  input  logic                 egress_clock,
  input  logic                 rst,
  input  logic                 wr_valid,
  input  smm_pkg::smm_wr_t     wr,
  input  logic                 rd_valid,
  input  smm_pkg::smm_rd_req_t rd_req,
  output logic                 rsp_valid,
  output smm_pkg::smm_rd_rsp_t rd_rsp
);

  localparam int MEM_WORDS  = MEM_SEGS * smm_pkg::smm_seg_words;
  localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

  // Word array, contents undefined after reset
  logic [smm_pkg::smm_word_w-1:0] mem_q [MEM_WORDS];

  logic [MEM_ADDR_W-1:0] wr_addr;
  logic [MEM_ADDR_W-1:0] rd_addr;

  // Only the low bits address the array
  assign wr_addr = wr.addr[MEM_ADDR_W-1:0];
  assign rd_addr = rd_req.addr[MEM_ADDR_W-1:0];

  // ====================
  // Write port
  // ====================
  always_ff @(posedge egress_clock) begin
    if (wr_valid) begin
      mem_q[wr_addr] <= wr.data;
    end
  end

  // ====================
  // Read port
  // ====================

  // Valid pipeline, one stage
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_valid;
    end
  end

  // Data plus sideband, back to back reads allowed
  // Same address write in this cycle returns the old word
  always_ff @(posedge egress_clock) begin
    if (rd_valid) begin
      rd_rsp.data <= mem_q[rd_addr];
      rd_rsp.port <= rd_req.port;
      rd_rsp.sop  <= rd_req.sop;
      rd_rsp.eop  <= rd_req.eop;
    end
  end

endmodule

`default_nettype wire

//--- egr_tag_queue.sv
/*
  Egress tag queue
  Circular FIFO of packet tags with full and not-empty levels,
  drops pushes while full and keeps a sticky overflow flag
*/
`default_nettype none
`timescale 1ns/100ps

module egr_tag_queue #(
  parameter int TAG_DEPTH = 8
) (
  input  logic              egress_clock,
  input  logic              rst,
  input  logic              push,
  input  egr_pkg::egr_tag_t push_tag,
  input  logic              pop,
  output egr_pkg::egr_tag_t head_tag,
  output logic              not_empty,
  output logic              full,
  output logic              overflow
);

  localparam int PTR_W = (TAG_DEPTH > 1) ? $clog2(TAG_DEPTH) : 1;
  localparam int CNT_W = $clog2(TAG_DEPTH + 1);

  // Tag storage, no reset
  egr_pkg::egr_tag_t tag_mem [TAG_DEPTH];

  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push_ok;

  // Pointer step with wrap for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(TAG_DEPTH - 1)) begin
      return '0;
    end else begin
      return ptr + 1'b1;
    end
  endfunction

  // Levels
  assign full      = (count_q == CNT_W'(TAG_DEPTH));
  assign not_empty = (count_q != '0);
  assign push_ok   = push && !full;

  // Head seen one cycle after its push
  assign head_tag = tag_mem[rd_ptr_q];

  // ====================
  // Storage
  // ====================
  always_ff @(posedge egress_clock) begin
    if (push_ok) begin
      tag_mem[wr_ptr_q] <= push_tag;
    end
  end

  // ====================
  // Pointers and count
  // ====================
  always_ff @(posedge egress_clock) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      overflow <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      // Only the generator pops, and only when not empty
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push_ok, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      // Sticky until reset
      if (push && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- egr_tb.sv
/*
  Egress subsystem testbench
  Fills the segment memory, sends packet tags and checks every egress
  port word against a memory mirror, with back-pressure and overflow
*/
`default_nettype none
`timescale 1ns/100ps

module egr_tb;

  localparam int NUM_PORTS = 4;
  localparam int TAG_DEPTH = 8;
  localparam int MEM_SEGS  = 64;
  localparam int MEM_WORDS = MEM_SEGS * 4;

  // ====================
  // Run length
  // ====================
  localparam int N_RAND_TAGS  = 24;
  localparam int N_BURST_TAGS = 6;
  localparam int N_BP_TAGS    = 5;
  // Blocker, a full queue and one dropped tag
  localparam int N_FULL_TAGS  = TAG_DEPTH + 2;
  localparam int TOTAL_TAGS   = N_RAND_TAGS + N_BURST_TAGS + N_BP_TAGS + N_FULL_TAGS;
  localparam int DIS_CYCLES   = 30;
  // Memory fill, twice the words, 20 per tag, two disable windows, slack
  localparam int CYCLE_LIMIT  = MEM_WORDS + 2 * (4 * TOTAL_TAGS) + 20 * TOTAL_TAGS
                              + 2 * DIS_CYCLES + 50;

  // Expected port word
  typedef struct packed {
    logic                           sop;
    logic                           eop;
    logic [smm_pkg::smm_word_w-1:0] data;
  } exp_word_t;

  logic                    egress_clock = 1'b0;
  logic                    rst;
  logic                    tag_valid;
  egr_pkg::egr_tag_t       tag;
  logic                    smm_wr_valid;
  smm_pkg::smm_wr_t        smm_wr;
  logic [NUM_PORTS-1:0]    port_enable;
  egr_pkg::egr_port_word_t port_out [NUM_PORTS];
  logic                    tag_full;
  logic                    tag_overflow;

  // Reference model
  logic [smm_pkg::smm_word_w-1:0] mirror [MEM_WORDS];
  exp_word_t                      exp_q [NUM_PORTS][$];
  logic [NUM_PORTS-1:0]           valid_bits;
  // High while the head tag's port is off
  logic                           silent;
  int                             cycle_cnt = 0;

  always #2 egress_clock = ~egress_clock;

  egr_top #(
    .NUM_PORTS (NUM_PORTS),
    .TAG_DEPTH (TAG_DEPTH),
    .MEM_SEGS  (MEM_SEGS)
  ) dut_i (
    .egress_clock (egress_clock),
    .rst          (rst),
    .tag_valid    (tag_valid),
    .tag          (tag),
    .smm_wr_valid (smm_wr_valid),
    .smm_wr       (smm_wr),
    .port_enable  (port_enable),
    .port_out     (port_out),
    .tag_full     (tag_full),
    .tag_overflow (tag_overflow)
  );

  // ====================
  // Checking helpers
  // ====================
  task automatic fail_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] want, input logic [31:0] got);
    assert (got === want)
      else fail_run($sformatf("[FAIL] %s expected %h actual %h", name, want, got));
  endtask

  task automatic check_bit(input string name, input logic want, input logic got);
    check_word(name, 32'(want), 32'(got));
  endtask

  task automatic check_reset_outputs();
    for (int p = 0; p < NUM_PORTS; p++) begin
      check_bit($sformatf("port_out[%0d].valid", p), 1'b0, port_out[p].valid);
    end
    check_bit("tag_full", 1'b0, tag_full);
    check_bit("tag_overflow", 1'b0, tag_overflow);
  endtask

  function automatic int pending_words();
    int total;
    total = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      total += exp_q[p].size();
    end
    return total;
  endfunction

  // ====================
  // Stimulus helpers
  // ====================
  task automatic write_word(input logic [7:0] addr, input logic [31:0] data);
    @(negedge egress_clock);
    smm_wr_valid = 1'b1;
    smm_wr.addr  = addr;
    smm_wr.data  = data;
    mirror[addr] = data;
  endtask

  // Tag words queued at pointer times 4 plus index
  task automatic send_tag(input logic [5:0] seg, input logic [1:0] cnt,
                          input logic [1:0] port, input bit accepted);
    exp_word_t w;
    @(negedge egress_clock);
    tag_valid    = 1'b1;
    tag.seg_ptr  = seg;
    tag.word_cnt = cnt;
    tag.port     = port;
    if (accepted) begin
      for (int i = 0; i <= int'(cnt); i++) begin
        w.sop  = (i == 0);
        w.eop  = (i == int'(cnt));
        w.data = mirror[8'(int'(seg) * 4 + i)];
        exp_q[port].push_back(w);
      end
    end
  endtask

  task automatic send_random_tag(input logic [1:0] port);
    logic [5:0] seg;
    logic [1:0] cnt;
    seg = 6'($urandom_range(MEM_SEGS - 1, 0));
    cnt = 2'($urandom_range(3, 0));
    send_tag(seg, cnt, port, 1'b1);
  endtask

  task automatic release_strobes();
    @(negedge egress_clock);
    tag_valid    = 1'b0;
    smm_wr_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge egress_clock);
  endtask

  task automatic wait_drain();
    while (pending_words() != 0) begin
      @(negedge egress_clock);
    end
    // A few more cycles to catch stray or repeated words
    idle_cycles(8);
  endtask

  // ====================
  // Output monitor
  // ====================
  always_comb begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      valid_bits[p] = port_out[p].valid;
    end
  end

  always @(posedge egress_clock) begin
    exp_word_t want;
    if (!rst) begin
      assert ($countones(valid_bits) <= 1)
        else fail_run("More than one egress port word valid in one cycle");
      assert (!(silent && (valid_bits != '0)))
        else fail_run("Port word seen while the head tag waits on a disabled port");
      for (int p = 0; p < NUM_PORTS; p++) begin
        if (port_out[p].valid) begin
          assert (exp_q[p].size() != 0)
            else fail_run($sformatf("Unexpected word on egress port %0d", p));
          want = exp_q[p].pop_front();
          check_word($sformatf("port_out[%0d].data", p), want.data, port_out[p].data);
          check_bit($sformatf("port_out[%0d].sop", p), want.sop, port_out[p].sop);
          check_bit($sformatf("port_out[%0d].eop", p), want.eop, port_out[p].eop);
        end
      end
    end
  end

  // Watchdog
  always @(posedge egress_clock) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      fail_run("Timeout, expected egress words are missing");
    end
  end

  // ====================
  // Test sequence
  // ====================
  initial begin
    rst          = 1'b1;
    tag_valid    = 1'b0;
    tag          = '0;
    smm_wr_valid = 1'b0;
    smm_wr       = '0;
    port_enable  = '1;
    silent       = 1'b0;
    void'($urandom(32'h5819_8ecc));

    // Outputs stay quiet through three reset cycles
    repeat (3) begin
      @(negedge egress_clock);
      check_reset_outputs();
    end
    rst = 1'b0;
    idle_cycles(2);
    check_reset_outputs();

    // Whole memory gets random words
    for (int a = 0; a < MEM_WORDS; a++) begin
      write_word(8'(a), $urandom());
    end
    release_strobes();

    // Spaced random tags with all ports on
    for (int n = 0; n < N_RAND_TAGS; n++) begin
      send_random_tag(2'($urandom_range(NUM_PORTS - 1, 0)));
      release_strobes();
      idle_cycles(5 + int'($urandom_range(3, 0)));
    end
    // Back to back tags where two ports get two each
    for (int n = 0; n < N_BURST_TAGS; n++) begin
      send_random_tag(2'(n % NUM_PORTS));
    end
    release_strobes();
    wait_drain();
    check_bit("tag_overflow", 1'b0, tag_overflow);

    // Port 1 off so its tag blocks the others
    port_enable[1] = 1'b0;
    silent         = 1'b1;
    send_random_tag(2'd1);
    send_random_tag(2'd0);
    send_random_tag(2'd2);
    send_random_tag(2'd3);
    send_random_tag(2'd1);
    release_strobes();
    idle_cycles(DIS_CYCLES);
    silent         = 1'b0;
    port_enable[1] = 1'b1;
    wait_drain();

    // Port 2 off with the blocker held in the generator
    port_enable[2] = 1'b0;
    silent         = 1'b1;
    send_random_tag(2'd2);
    release_strobes();
    idle_cycles(4);
    for (int n = 0; n < TAG_DEPTH; n++) begin
      check_bit("tag_full", 1'b0, tag_full);
      send_random_tag(2'($urandom_range(NUM_PORTS - 1, 0)));
    end
    release_strobes();
    check_bit("tag_full", 1'b1, tag_full);
    check_bit("tag_overflow", 1'b0, tag_overflow);

    // Dropped tag is never expected
    send_tag(6'($urandom_range(MEM_SEGS - 1, 0)), 2'd3, 2'd0, 1'b0);
    release_strobes();
    check_bit("tag_overflow", 1'b1, tag_overflow);
    check_bit("tag_full", 1'b1, tag_full);
    idle_cycles(DIS_CYCLES);
    silent         = 1'b0;
    port_enable[2] = 1'b1;
    wait_drain();
    // Sticky flag
    check_bit("tag_overflow", 1'b1, tag_overflow);
    check_bit("tag_full", 1'b0, tag_full);

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- egr_top.sv
/*
  Egress top level
  Tag queue, read request generator, segment memory and port stage
*/
`default_nettype none
`timescale 1ns/100ps

module egr_top #(
  parameter int NUM_PORTS = 4,
  parameter int TAG_DEPTH = 8,
  parameter int MEM_SEGS  = 64
) (
  input  logic                    egress_clock,
  input  logic                    rst,
  input  logic                    tag_valid,
  input  egr_pkg::egr_tag_t       tag,
  input  logic                    smm_wr_valid,
  input  smm_pkg::smm_wr_t        smm_wr,
  input  logic [NUM_PORTS-1:0]    port_enable,
  output egr_pkg::egr_port_word_t port_out [NUM_PORTS],
  output logic                    tag_full,
  output logic                    tag_overflow
);

  // ====================
  // Internal nets
  // ====================

  // Queue to generator
  egr_pkg::egr_tag_t    head_tag;
  logic                 tag_not_empty;
  logic                 tag_pop;

  // Generator to memory
  logic                 rd_valid;
  smm_pkg::smm_rd_req_t rd_req;

  // Memory to port stage
  logic                 rsp_valid;
  smm_pkg::smm_rd_rsp_t rd_rsp;

  egr_tag_queue #(
    .TAG_DEPTH (TAG_DEPTH)
  ) tag_queue_i (
    .egress_clock (egress_clock),
    .rst          (rst),
    .push         (tag_valid),
    .push_tag     (tag),
    .pop          (tag_pop),
    .head_tag     (head_tag),
    .not_empty    (tag_not_empty),
    .full         (tag_full),
    .overflow     (tag_overflow)
  );

  egr_rd_req_gen #(
    .NUM_PORTS (NUM_PORTS),
    .MEM_SEGS  (MEM_SEGS)
  ) rd_req_gen_i (
    .egress_clock (egress_clock),
    .rst          (rst),
    .head_tag     (head_tag),
    .not_empty    (tag_not_empty),
    .port_enable  (port_enable),
    .pop          (tag_pop),
    .rd_valid     (rd_valid),
    .rd_req       (rd_req)
  );

  // Testbench writes stand in for ingress
  egr_seg_mem #(
    .MEM_SEGS (MEM_SEGS)
  ) seg_mem_i (
    .egress_clock (egress_clock),
    .rst          (rst),
    .wr_valid     (smm_wr_valid),
    .wr           (smm_wr),
    .rd_valid     (rd_valid),
    .rd_req       (rd_req),
    .rsp_valid    (rsp_valid),
    .rd_rsp       (rd_rsp)
  );

  egr_port_tx #(
    .NUM_PORTS (NUM_PORTS)
  ) port_tx_i (
    .egress_clock (egress_clock),
    .rst          (rst),
    .rsp_valid    (rsp_valid),
    .rd_rsp       (rd_rsp),
    .port_out     (port_out)
  );

endmodule

`default_nettype wire

//--- project.f
smm_pkg.sv
egr_pkg.sv
egr_tag_queue.sv
egr_rd_req_gen.sv
egr_seg_mem.sv
egr_port_tx.sv
egr_top.sv
egr_tb.sv

//--- smm_pkg.sv
/*
  Segment memory package
  Word and address widths of the shared segment memory, plus the write,
  read request and read response records used by its clients
*/
`default_nettype none

package smm_pkg;

  // ====================
  // Sizes
  // ====================

  // Data word width
  localparam int smm_word_w = 32;

  // Words held by one segment
  localparam int smm_seg_words = 4;

  // Word address width, wide enough for 64 segments of 4 words
  localparam int smm_addr_w = 8;

  // Sideband port index carried with a read
  localparam int smm_sb_port_w = 2;

  // ====================
  // Records
  // ====================

  // One memory write
  typedef struct packed {
    logic [smm_addr_w-1:0] addr;
    logic [smm_word_w-1:0] data;
  } smm_wr_t;

  // One read request, sideband comes back untouched
  typedef struct packed {
    logic [smm_addr_w-1:0]    addr;
    logic [smm_sb_port_w-1:0] port;
    logic                     sop;
    logic                     eop;
  } smm_rd_req_t;

  // One read response
  typedef struct packed {
    logic [smm_word_w-1:0]    data;
    logic [smm_sb_port_w-1:0] port;
    logic                     sop;
    logic                     eop;
  } smm_rd_rsp_t;

endpackage

`default_nettype wire
